// ==== branchRsPkg.sv ====
`default_nettype none

package branchRsPkg;

    localparam int TAG_W = 8;      // physical register tag
    localparam int DATA_W = 32;
    localparam int NUM_BUSES = 4;  // alu, mul, div, load

    // one result broadcast
    // load bus valid already carries the mem-read qualifier
    typedef struct packed {
        logic valid;
        logic [TAG_W-1:0] tag;
        logic [DATA_W-1:0] data;
    } resultBus_t;

    // source operand, data only meaningful once ready
    typedef struct packed {
        logic ready;
        logic [TAG_W-1:0] tag;
        logic [DATA_W-1:0] data;
    } operand_t;

    // fields carried untouched from dispatch to the branch unit
    typedef struct packed {
        logic [31:0] instNum;
        logic [31:0] pc;
        logic [TAG_W-1:0] destTag;
        logic [2:0] funct3;
        logic jump;
        logic branch;
        logic [31:0] imm;
        logic predTaken;    // predictor said taken
        logic predHit;      // btb hit at fetch
    } branchInfo_t;

    typedef struct packed {
        branchInfo_t info;
        operand_t src1;
        operand_t src2;
    } rsEntry_t;

    // what leaves for the branch unit, tags no longer needed
    typedef struct packed {
        branchInfo_t info;
        logic [DATA_W-1:0] src1Data;
        logic [DATA_W-1:0] src2Data;
    } issueOp_t;

endpackage

`default_nettype wire

// ==== operandSnoop.sv ====
`timescale 1ns/100ps
`default_nettype none

module operandSnoop (
    input  branchRsPkg::operand_t operand,
    input  branchRsPkg::resultBus_t [branchRsPkg::NUM_BUSES-1:0] buses,
    output branchRsPkg::operand_t resolved
);
    import branchRsPkg::*;

    // walk from the top bus down so the lowest matching bus is applied last
    always_comb begin
        resolved = operand;
        for (int i = NUM_BUSES - 1; i >= 0; i--) begin
            if (!operand.ready && buses[i].valid && (buses[i].tag == operand.tag)) begin
                resolved.ready = 1'b1;
                resolved.data = buses[i].data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dispatchCapture.sv ====
`timescale 1ns/100ps
`default_nettype none

module dispatchCapture (
    input  logic clk,
    input  logic reset,
    input  logic dispatchValid,
    input  branchRsPkg::rsEntry_t dispatchOp,
    input  branchRsPkg::resultBus_t [branchRsPkg::NUM_BUSES-1:0] buses,
    output logic capValid,
    output branchRsPkg::rsEntry_t capEntry
);
    import branchRsPkg::*;

    operand_t inSrc1;
    operand_t inSrc2;
    operand_t heldSrc1;
    operand_t heldSrc2;
    rsEntry_t held;
    logic heldValid;

    // bypass of broadcasts in the dispatch cycle
    operandSnoop snoopIn1 (
        .operand(dispatchOp.src1),
        .buses(buses),
        .resolved(inSrc1)
    );

    operandSnoop snoopIn2 (
        .operand(dispatchOp.src2),
        .buses(buses),
        .resolved(inSrc2)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            heldValid <= 1'b0;
        end else begin
            heldValid <= dispatchValid;  // array always has room, credits see to that
        end
    end

    always_ff @(posedge clk) begin
        if (dispatchValid) begin
            held.info <= dispatchOp.info;
            held.src1 <= inSrc1;
            held.src2 <= inSrc2;
        end
    end

    // second look while the op sits here for one cycle
    operandSnoop snoopHeld1 (
        .operand(held.src1),
        .buses(buses),
        .resolved(heldSrc1)
    );

    operandSnoop snoopHeld2 (
        .operand(held.src2),
        .buses(buses),
        .resolved(heldSrc2)
    );

    assign capValid = heldValid;
    assign capEntry = '{info: held.info, src1: heldSrc1, src2: heldSrc2};

endmodule

`default_nettype wire

// ==== entryArray.sv ====
`timescale 1ns/100ps
`default_nettype none

module entryArray #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic capValid,
    input  branchRsPkg::rsEntry_t capEntry,
    input  branchRsPkg::resultBus_t [branchRsPkg::NUM_BUSES-1:0] buses,
    input  logic issueFire,
    input  logic [NUM_ENTRIES-1:0] grantOneHot,
    output logic [NUM_ENTRIES-1:0] readyVec,
    output logic [NUM_ENTRIES-1:0] allocOneHot,
    output branchRsPkg::rsEntry_t [NUM_ENTRIES-1:0] entries
);
    import branchRsPkg::*;

    logic [NUM_ENTRIES-1:0] validVec;
    logic [NUM_ENTRIES-1:0] freeVec;
    logic [NUM_ENTRIES-1:0] clearVec;
    rsEntry_t [NUM_ENTRIES-1:0] slots;
    operand_t woken1 [NUM_ENTRIES];
    operand_t woken2 [NUM_ENTRIES];

    assign freeVec = ~validVec;

    // lowest free slot, isolated by x & -x
    assign allocOneHot = capValid ? (freeVec & (~freeVec + NUM_ENTRIES'(1))) : '0;

    assign clearVec = issueFire ? grantOneHot : '0;

    // wakeup logic, one pair of comparators per slot
    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : gWake
        operandSnoop wake1 (
            .operand(slots[i].src1),
            .buses(buses),
            .resolved(woken1[i])
        );

        operandSnoop wake2 (
            .operand(slots[i].src2),
            .buses(buses),
            .resolved(woken2[i])
        );
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            validVec <= '0;
        end else begin
            // alloc never lands on a granted slot, both can happen together
            validVec <= (validVec | allocOneHot) & ~clearVec;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (allocOneHot[i]) begin
                slots[i] <= capEntry;
            end else begin
                slots[i].src1 <= woken1[i];
                slots[i].src2 <= woken2[i];
            end
        end
    end

    // ready from stored state only, a wakeup counts one edge later
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            readyVec[i] = validVec[i] & slots[i].src1.ready & slots[i].src2.ready;
        end
    end

    assign entries = slots;

endmodule

`default_nettype wire

// ==== ageSelect.sv ====
`timescale 1ns/100ps
`default_nettype none

module ageSelect #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic [NUM_ENTRIES-1:0] allocOneHot,
    input  logic [NUM_ENTRIES-1:0] readyVec,
    output logic [NUM_ENTRIES-1:0] grantOneHot
);

    // olderMat[i][j] set means slot j was allocated before slot i
    logic [NUM_ENTRIES-1:0][NUM_ENTRIES-1:0] olderMat;

    // New row: every other slot counts as older. Rows of empty slots are
    // harmless because an empty slot is never ready, and the column of the
    // new slot is cleared so nobody waits on it.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            olderMat <= '0;
        end else begin
            for (int r = 0; r < NUM_ENTRIES; r++) begin
                if (allocOneHot[r]) begin
                    olderMat[r] <= ~allocOneHot;  // diagonal stays clear
                end else begin
                    olderMat[r] <= olderMat[r] & ~allocOneHot;
                end
            end
        end
    end

    // oldest ready entry, the one with no older ready entry
    always_comb begin
        for (int r = 0; r < NUM_ENTRIES; r++) begin
            grantOneHot[r] = readyVec[r] & ~(|(olderMat[r] & readyVec));
        end
    end

endmodule

`default_nettype wire

// ==== issueStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module issueStage #(
    parameter int NUM_ENTRIES = 8,
    parameter int ISSUE_CREDITS = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic [NUM_ENTRIES-1:0] grantOneHot,
    input  branchRsPkg::rsEntry_t [NUM_ENTRIES-1:0] entries,
    input  logic issueCredit,
    output logic issueFire,
    output logic issueValid,
    output branchRsPkg::issueOp_t issueOp,
    output logic dispatchCredit
);
    import branchRsPkg::*;

    localparam int CNT_W = $clog2(ISSUE_CREDITS + 1);

    logic [CNT_W-1:0] creditCount;
    rsEntry_t picked;

    // grant is one-hot, so a plain priority loop acts as an and-or mux
    always_comb begin
        picked = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (grantOneHot[i]) begin
                picked = entries[i];
            end
        end
    end

    assign issueFire = (|grantOneHot) && (creditCount != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            creditCount <= CNT_W'(ISSUE_CREDITS);
            issueValid <= 1'b0;
            dispatchCredit <= 1'b0;
        end else begin
            creditCount <= creditCount + CNT_W'(issueCredit) - CNT_W'(issueFire);
            issueValid <= issueFire;
            dispatchCredit <= issueFire;  // slot frees on the same edge
        end
    end

    always_ff @(posedge clk) begin
        if (issueFire) begin
            issueOp.info <= picked.info;
            issueOp.src1Data <= picked.src1.data;
            issueOp.src2Data <= picked.src2.data;
        end
    end

endmodule

`default_nettype wire

// ==== branchRsTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module branchRsTop #(
    parameter int NUM_ENTRIES = 8,
    parameter int ISSUE_CREDITS = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic dispatchValid,
    input  branchRsPkg::rsEntry_t dispatchOp,
    output logic dispatchCredit,
    input  branchRsPkg::resultBus_t [branchRsPkg::NUM_BUSES-1:0] resultBuses,
    input  logic issueCredit,
    output logic issueValid,
    output branchRsPkg::issueOp_t issueOp
);
    import branchRsPkg::*;

    logic capValid;
    rsEntry_t capEntry;
    logic [NUM_ENTRIES-1:0] readyVec;
    logic [NUM_ENTRIES-1:0] allocOneHot;
    logic [NUM_ENTRIES-1:0] grantOneHot;
    rsEntry_t [NUM_ENTRIES-1:0] entries;
    logic issueFire;

    dispatchCapture capture (
        .clk(clk),
        .reset(reset),
        .dispatchValid(dispatchValid),
        .dispatchOp(dispatchOp),
        .buses(resultBuses),
        .capValid(capValid),
        .capEntry(capEntry)
    );

    entryArray #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) array (
        .clk(clk),
        .reset(reset),
        .capValid(capValid),
        .capEntry(capEntry),
        .buses(resultBuses),
        .issueFire(issueFire),
        .grantOneHot(grantOneHot),
        .readyVec(readyVec),
        .allocOneHot(allocOneHot),
        .entries(entries)
    );

    ageSelect #(
        .NUM_ENTRIES(NUM_ENTRIES)
    ) select (
        .clk(clk),
        .reset(reset),
        .allocOneHot(allocOneHot),
        .readyVec(readyVec),
        .grantOneHot(grantOneHot)
    );

    issueStage #(
        .NUM_ENTRIES(NUM_ENTRIES),
        .ISSUE_CREDITS(ISSUE_CREDITS)
    ) issue (
        .clk(clk),
        .reset(reset),
        .grantOneHot(grantOneHot),
        .entries(entries),
        .issueCredit(issueCredit),
        .issueFire(issueFire),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .dispatchCredit(dispatchCredit)
    );

endmodule

`default_nettype wire

// ==== branchRsTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module branchRsTb;
    import branchRsPkg::*;

    localparam int NUM_ENTRIES = 8;
    localparam int ISSUE_CREDITS = 2;
    localparam int TEST_WORDS = 512;
    localparam int MAX_RECS = 128;

    logic clk;
    logic reset;
    logic dispatchValid;
    rsEntry_t dispatchOp;
    logic dispatchCredit;
    resultBus_t [NUM_BUSES-1:0] resultBuses;
    logic issueCredit;
    logic issueValid;
    issueOp_t issueOp;

    logic [31:0] testMem [0:TEST_WORDS-1];
    int stimPos [0:MAX_RECS-1];
    int stimCount;
    issueOp_t expOps [0:MAX_RECS-1];
    int expTests [0:MAX_RECS-1];
    int expCount;
    int expIdx;
    int totalCycles;
    logic loaded;

    int dispCredits;      // dispatcher side credit count
    int creditsReturned;  // issue credits handed back by the branch unit
    int issued;
    int valueErrors;
    int otherErrors;

    branchRsTop #(
        .NUM_ENTRIES(NUM_ENTRIES),
        .ISSUE_CREDITS(ISSUE_CREDITS)
    ) UUT (
        .clk(clk),
        .reset(reset),
        .dispatchValid(dispatchValid),
        .dispatchOp(dispatchOp),
        .dispatchCredit(dispatchCredit),
        .resultBuses(resultBuses),
        .issueCredit(issueCredit),
        .issueValid(issueValid),
        .issueOp(issueOp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // pass-through fields are a fixed function of the instruction number
    function automatic branchInfo_t makeInfo(input logic [7:0] inst);
        branchInfo_t info;
        info.instNum = {24'h0, inst};
        info.pc = 32'h0000_4000 + {22'h0, inst, 2'b00};
        info.destTag = inst + 8'h40;
        info.funct3 = inst[2:0];
        info.jump = inst[3];
        info.branch = ~inst[3];
        info.imm = {20'h0, inst, 4'h8};
        info.predTaken = inst[0];
        info.predHit = inst[1];
        return info;
    endfunction

    // broadcast data carries the bus number so the winning bus is visible
    function automatic logic [DATA_W-1:0] busValue(input int bus, input logic [TAG_W-1:0] tag);
        return {4'hD, 4'(bus), 16'h0000, tag};
    endfunction

    function automatic string testName(input int id);
        case (id)
            1: return "readyAtDispatch";
            2: return "wakeup";
            3: return "bypass";
            4: return "fullOccupancy";
            default: return "unknown";
        endcase
    endfunction

    // first pass over the file, collects stimulus offsets and expected issues
    task automatic scanTests();
        int p;
        logic scanning;
        logic [31:0] kind;
        issueOp_t rec;
        p = 0;
        scanning = 1'b1;
        stimCount = 0;
        expCount = 0;
        totalCycles = 0;
        while (scanning) begin
            kind = testMem[p];
            if (kind === 32'h1 && stimCount < MAX_RECS) begin
                stimPos[stimCount] = p;
                stimCount++;
                totalCycles += 1 + int'(testMem[p + 1]);
                p += 11;
            end else if (kind === 32'h2 && expCount < MAX_RECS) begin
                rec.info = makeInfo(testMem[p + 2][7:0]);
                rec.src1Data = testMem[p + 3];
                rec.src2Data = testMem[p + 4];
                expOps[expCount] = rec;
                expTests[expCount] = int'(testMem[p + 1]);
                expCount++;
                p += 5;
            end else if (kind === 32'hF) begin
                scanning = 1'b0;
            end else begin
                $display("test file has an unreadable record at word %0d", p);
                otherErrors++;
                scanning = 1'b0;
            end
            if (p >= TEST_WORDS - 11) begin
                $display("test file runs past its buffer without an end marker");
                otherErrors++;
                scanning = 1'b0;
            end
        end
    endtask

    // one stimulus record, its inputs in the first cycle then gap idle cycles
    task automatic driveRecord(input int p);
        int gap;
        int credits;
        int i;
        int j;
        rsEntry_t op;
        resultBus_t [NUM_BUSES-1:0] bus;
        gap = int'(testMem[p + 1]);
        credits = int'(testMem[p + 10]);
        op.info = makeInfo(testMem[p + 3][7:0]);
        op.src1.ready = testMem[p + 4][8];
        op.src1.tag = testMem[p + 4][TAG_W-1:0];
        op.src1.data = testMem[p + 5];
        op.src2.ready = testMem[p + 6][8];
        op.src2.tag = testMem[p + 6][TAG_W-1:0];
        op.src2.data = testMem[p + 7];
        for (i = 0; i < NUM_BUSES; i++) begin
            bus[i].valid = testMem[p + 8][i];
            bus[i].tag = testMem[p + 9][TAG_W*i +: TAG_W];
            bus[i].data = busValue(i, bus[i].tag);
        end
        for (j = 0; j <= gap; j++) begin
            @(posedge clk);
            #1;
            if (j == 0 && testMem[p + 2][0] === 1'b1) begin
                if (dispCredits <= 0) begin
                    $display("instruction %0h dispatched without a dispatch credit",
                             op.info.instNum);
                    otherErrors++;
                end
                dispCredits--;
                dispatchValid = 1'b1;
                dispatchOp = op;
            end else begin
                dispatchValid = 1'b0;
                dispatchOp = '0;
            end
            resultBuses = (j == 0) ? bus : '0;
            issueCredit = (j < credits);
            if (j < credits) begin
                creditsReturned++;
            end
        end
    endtask

    task automatic checkIssue();
        issued++;
        if (issued > ISSUE_CREDITS + creditsReturned) begin
            $display("ERR issueCredits expected at most %0d issues actual %0d",
                     ISSUE_CREDITS + creditsReturned, issued);
            valueErrors++;
        end
        if (expIdx >= expCount) begin
            $display("instruction %0h issued after the last expected issue",
                     issueOp.info.instNum);
            otherErrors++;
        end else begin
            if (issueOp !== expOps[expIdx]) begin
                $display("ERR %s expected %h actual %h", testName(expTests[expIdx]),
                         expOps[expIdx], issueOp);
                valueErrors++;
            end
            expIdx++;
        end
    endtask

    // outputs looked at mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            if (issueValid !== 1'b0 || dispatchCredit !== 1'b0) begin
                $display("ERR resetState expected 00 actual %b%b", issueValid, dispatchCredit);
                valueErrors++;
            end
        end else begin
            if (dispatchCredit !== issueValid) begin
                $display("ERR dispatchCredits expected %b actual %b", issueValid, dispatchCredit);
                valueErrors++;
            end
            if (dispatchCredit === 1'b1) begin
                dispCredits++;
            end
            if (issueValid === 1'b1) begin
                checkIssue();
            end
        end
    end

    initial begin
        wait (loaded === 1'b1);
        #((totalCycles + 100) * 10);
        $display("timeout, %0d of %0d expected issues seen", expIdx, expCount);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int r;
        reset = 1'b1;
        dispatchValid = 1'b0;
        dispatchOp = '0;
        resultBuses = '0;
        issueCredit = 1'b0;
        loaded = 1'b0;
        dispCredits = NUM_ENTRIES;
        creditsReturned = 0;
        issued = 0;
        expIdx = 0;
        valueErrors = 0;
        otherErrors = 0;
        $readmemh("branchRsTests.mem", testMem);
        scanTests();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (r = 0; r < stimCount; r++) begin
            driveRecord(stimPos[r]);
        end
        @(posedge clk);
        #1;
        dispatchValid = 1'b0;
        resultBuses = '0;
        issueCredit = 1'b0;
        while (expIdx < expCount) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);  // room for any stray issue
        if (dispCredits != NUM_ENTRIES) begin
            $display("ERR dispatchCredits expected %0d actual %0d", NUM_ENTRIES, dispCredits);
            valueErrors++;
        end
        $display("errors %0d value %0d other, %0d issues of %0d expected",
                 valueErrors, otherErrors, issued, expCount);
        if (valueErrors + otherErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== branchRsTests.mem ====
// stimulus 1 gap disp inst src1 src1Data src2 src2Data busMask busTags credits (all hex)
// expected issue 2 test inst src1Data src2Data in issue order, src is ready bit over tag, F ends
// ready at dispatch, the third waits for a returned credit
1 0 1 01 100 0A000001 100 0B000001 0 00000000 0
1 0 1 02 100 0A000002 100 0B000002 0 00000000 0
1 5 1 03 100 0A000003 100 0B000003 0 00000000 0
1 3 0 00 000 00000000 000 00000000 0 00000000 1
1 4 0 00 000 00000000 000 00000000 0 00000000 2
// wakeup on the MUL bus, a stray tag first
1 0 1 04 021 00000000 100 0B000004 0 00000000 0
1 5 1 05 100 0A000005 100 0B000005 1 00000022 0
1 5 0 00 000 00000000 000 00000000 2 00002100 0
1 4 0 00 000 00000000 000 00000000 0 00000000 2
// bypass in the dispatch cycle and the cycle after
1 0 1 06 030 00000000 031 00000000 5 00300030 0
1 0 1 07 100 0A000007 032 00000000 8 31000000 0
1 6 0 00 000 00000000 000 00000000 A 32003200 0
// fill all entries with no issue credits
1 0 1 08 100 0A000008 100 0B000008 0 00000000 0
1 0 1 09 100 0A000009 100 0B000009 0 00000000 0
1 0 1 0A 100 0A00000A 100 0B00000A 0 00000000 0
1 0 1 0B 100 0A00000B 100 0B00000B 0 00000000 0
1 0 1 0C 100 0A00000C 100 0B00000C 0 00000000 0
1 0 1 0D 100 0A00000D 100 0B00000D 0 00000000 0
1 0 1 0E 100 0A00000E 100 0B00000E 0 00000000 0
1 5 1 0F 100 0A00000F 100 0B00000F 0 00000000 0
1 7 0 00 000 00000000 000 00000000 0 00000000 3
1 0 1 10 100 0A000010 100 0B000010 0 00000000 0
1 5 1 11 100 0A000011 100 0B000011 0 00000000 0
1 10 0 00 000 00000000 000 00000000 0 00000000 7
// expected issue order
2 1 01 0A000001 0B000001 2 1 02 0A000002 0B000002
2 1 03 0A000003 0B000003
2 2 05 0A000005 0B000005 2 2 04 D1000021 0B000004
2 3 06 D0000030 D3000031 2 3 07 0A000007 D1000032
2 4 08 0A000008 0B000008 2 4 09 0A000009 0B000009
2 4 0A 0A00000A 0B00000A 2 4 0B 0A00000B 0B00000B
2 4 0C 0A00000C 0B00000C 2 4 0D 0A00000D 0B00000D
2 4 0E 0A00000E 0B00000E 2 4 0F 0A00000F 0B00000F
2 4 10 0A000010 0B000010 2 4 11 0A000011 0B000011
F

// ==== filelist.f ====
branchRsPkg.sv
operandSnoop.sv
dispatchCapture.sv
entryArray.sv
ageSelect.sv
issueStage.sv
branchRsTop.sv
branchRsTb.sv
